/* verilog/riscv_settings.svh */
////////////////////
// Core-wide sizes and the reset PC
// Included by the package and by every module that sizes a port
////////////////////
`ifndef RISCV_SETTINGS_SVH
`define RISCV_SETTINGS_SVH

// Architectural integer registers, x0 included
`define RISCV_REG_COUNT 32

// First fetch address after reset
`define RISCV_RESET_PC 32'h0000_0000

// Data, address and instruction width
`define RISCV_XLEN 32

`endif

/* verilog/riscv_pkg.sv */
////////////////////
// Opcode encodings, instruction views and pipeline records
// Imported by every stage of the core and by the testbench
////////////////////
`default_nettype none
`include "riscv_settings.svh"

package riscv_pkg;

    // Major opcodes the core executes
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } t_opcode;

    // ALU and branch codes share the same three bits
    typedef enum logic [2:0] {
        F3_ADD_BEQ  = 3'b000,
        F3_SLL_BNE  = 3'b001,
        F3_SLT      = 3'b010,
        F3_SLTU     = 3'b011,
        F3_XOR_BLT  = 3'b100,
        F3_SR_BGE   = 3'b101,
        F3_OR_BLTU  = 3'b110,
        F3_AND_BGEU = 3'b111
    } t_funct3;

    typedef enum logic [6:0] {
        F7_BASE = 7'b0000000,
        F7_ALT  = 7'b0100000
    } t_funct7;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
        ALU_PASS_B,    // lui, operand b is the immediate
        ALU_LINK       // jal, return address
    } t_alu_op;

    // Register fields of the word
    typedef struct packed {
        t_funct7    funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        t_funct3    funct3;
        logic [4:0] rd;
        t_opcode    opcode;
    } t_instr_r;

    // Immediate pieces, named by bit position in the word
    typedef struct packed {
        logic       b31;
        logic [5:0] b30_25;
        logic [3:0] b24_21;
        logic       b20;
        logic [7:0] b19_12;
        logic [3:0] b11_8;
        logic       b7;
        t_opcode    opcode;
    } t_instr_imm;

    typedef union packed {
        t_instr_r   r;
        t_instr_imm imm;
    } t_instr;

    typedef struct packed {
        logic                   valid;
        logic [`RISCV_XLEN-1:0] pc;
        t_instr                 instr;
    } if_id_t;

    typedef struct packed {
        logic                   valid;
        logic [`RISCV_XLEN-1:0] pc;
        t_alu_op                alu_op;
        logic [`RISCV_XLEN-1:0] operand_a;
        logic [`RISCV_XLEN-1:0] operand_b;
        logic [4:0]             rd;
        logic                   writes_rd;
    } id_ex_t;

    typedef struct packed {
        logic                   redirect;
        logic [`RISCV_XLEN-1:0] target;
    } if_ctrl_t;

    // One retired register write
    typedef struct packed {
        logic                   valid;
        logic [`RISCV_XLEN-1:0] pc;
        logic [4:0]             rd;
        logic [`RISCV_XLEN-1:0] data;
    } commit_t;

endpackage

`default_nettype wire

/* verilog/imm_gen.sv */
////////////////////
// Immediate generator for I, B, U and J formats
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module imm_gen (
    input  riscv_pkg::t_instr      instr,
    output logic [`RISCV_XLEN-1:0] immediate
);

    import riscv_pkg::*;

    t_instr_imm f;

    assign f = instr.imm;

    always_comb begin
        case (f.opcode)
            OPC_OP_IMM: begin
                immediate = {{21{f.b31}}, f.b30_25, f.b24_21, f.b20};
            end
            OPC_BRANCH: begin
                immediate = {{20{f.b31}}, f.b7, f.b30_25, f.b11_8, 1'b0};
            end
            OPC_LUI: begin
                immediate = {f.b31, f.b30_25, f.b24_21, f.b20, f.b19_12, 12'b0};
            end
            OPC_JAL: begin
                immediate = {{12{f.b31}}, f.b19_12, f.b20, f.b30_25, f.b24_21, 1'b0};
            end
            // R-type and anything unsupported
            default: begin
                immediate = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* verilog/bu.sv */
////////////////////
// Branch unit, resolves conditional branches and jal in decode
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module bu (
    input  logic                   valid,
    input  riscv_pkg::t_instr      instr,
    input  logic [`RISCV_XLEN-1:0] pc,
    input  logic [`RISCV_XLEN-1:0] operand_a,
    input  logic [`RISCV_XLEN-1:0] operand_b,
    input  logic [`RISCV_XLEN-1:0] immediate,
    output riscv_pkg::if_ctrl_t    if_ctrl
);

    import riscv_pkg::*;

    logic taken;

    always_comb begin
        taken = 1'b0;
        if (valid && instr.r.opcode == OPC_JAL) begin
            taken = 1'b1;
        end else if (valid && instr.r.opcode == OPC_BRANCH) begin
            case (instr.r.funct3)
                F3_ADD_BEQ:  taken = operand_a == operand_b;
                F3_SLL_BNE:  taken = operand_a != operand_b;
                F3_XOR_BLT:  taken = $signed(operand_a) < $signed(operand_b);
                F3_SR_BGE:   taken = $signed(operand_a) >= $signed(operand_b);
                F3_OR_BLTU:  taken = operand_a < operand_b;
                F3_AND_BGEU: taken = operand_a >= operand_b;
                // 010 and 011 are not branch codes
                default:     taken = 1'b0;
            endcase
        end
    end

    assign if_ctrl = '{redirect: taken, target: pc + immediate};

endmodule

`default_nettype wire

/* verilog/register_file.sv */
////////////////////
// Integer register file, two async reads, one sync write
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module register_file (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  logic [4:0]             rs1,
    input  logic [4:0]             rs2,
    input  riscv_pkg::commit_t     wb,
    output logic [`RISCV_XLEN-1:0] read_data1,
    output logic [`RISCV_XLEN-1:0] read_data2
);

    logic [`RISCV_XLEN-1:0] regs [`RISCV_REG_COUNT];

    // x0 reads as zero whatever the array holds
    assign read_data1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign read_data2 = (rs2 == 5'd0) ? '0 : regs[rs2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `RISCV_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (en && wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

`default_nettype wire

/* verilog/fetch.sv */
////////////////////
// Fetch stage, owns the PC and the fetch-to-decode register
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  riscv_pkg::if_ctrl_t    if_ctrl,
    input  riscv_pkg::t_instr      instr,
    output logic [`RISCV_XLEN-1:0] instr_addr,
    output riscv_pkg::if_id_t      if_id
);

    import riscv_pkg::*;

    logic [`RISCV_XLEN-1:0] pc;
    if_id_t                 fetched;

    assign instr_addr = pc;

    // Word behind a taken branch is dropped
    assign fetched = '{
        valid: !if_ctrl.redirect,
        pc:    pc,
        instr: instr
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RISCV_RESET_PC;
        end else if (en) begin
            if (if_ctrl.redirect) begin
                pc <= if_ctrl.target;
            end else begin
                pc <= pc + `RISCV_XLEN'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_id <= '0;
        end else if (en) begin
            if_id <= fetched;
        end
    end

endmodule

`default_nettype wire

/* verilog/dec.sv */
////////////////////
// Decode stage: operand fetch with forwarding, control, branch resolve
// Loads the decode-to-execute register and steers fetch on redirects
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module dec (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                en,
    input  riscv_pkg::if_id_t   if_id,
    input  riscv_pkg::commit_t  ex_fwd,
    input  riscv_pkg::commit_t  wb,
    output riscv_pkg::id_ex_t   id_ex,
    output riscv_pkg::if_ctrl_t if_ctrl
);

    import riscv_pkg::*;

    t_instr                 instr;
    logic [`RISCV_XLEN-1:0] rf_data1;
    logic [`RISCV_XLEN-1:0] rf_data2;
    logic [`RISCV_XLEN-1:0] rs1_val;
    logic [`RISCV_XLEN-1:0] rs2_val;
    logic [`RISCV_XLEN-1:0] immediate;
    t_alu_op                alu_op;
    logic                   writes_rd;
    logic                   uses_imm;

    // Execute result first, then writeback, then the register file
    function automatic logic [`RISCV_XLEN-1:0] forward(
        input logic [4:0]             src,
        input logic [`RISCV_XLEN-1:0] rf_val
    );
        if (src == 5'd0) return '0;
        if (ex_fwd.valid && ex_fwd.rd == src) return ex_fwd.data;
        if (wb.valid && wb.rd == src) return wb.data;
        return rf_val;
    endfunction

    // alt selects sub (register form only) and sra
    function automatic t_alu_op alu_from_funct(
        input t_funct3 f3,
        input logic    alt,
        input logic    reg_form
    );
        case (f3)
            F3_ADD_BEQ: return (alt && reg_form) ? ALU_SUB : ALU_ADD;
            F3_SLL_BNE: return ALU_SLL;
            F3_SLT:     return ALU_SLT;
            F3_SLTU:    return ALU_SLTU;
            F3_XOR_BLT: return ALU_XOR;
            F3_SR_BGE:  return alt ? ALU_SRA : ALU_SRL;
            F3_OR_BLTU: return ALU_OR;
            default:    return ALU_AND;
        endcase
    endfunction

    assign instr = if_id.instr;

    always_comb begin
        rs1_val = forward(instr.r.rs1, rf_data1);
        rs2_val = forward(instr.r.rs2, rf_data2);
    end

    always_comb begin
        alu_op    = ALU_ADD;
        writes_rd = 1'b0;
        uses_imm  = 1'b0;
        case (instr.r.opcode)
            OPC_OP: begin
                alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7 == F7_ALT, 1'b1);
                writes_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                alu_op    = alu_from_funct(instr.r.funct3, instr.r.funct7 == F7_ALT, 1'b0);
                writes_rd = 1'b1;
                uses_imm  = 1'b1;
            end
            OPC_LUI: begin
                alu_op    = ALU_PASS_B;
                writes_rd = 1'b1;
                uses_imm  = 1'b1;
            end
            OPC_JAL: begin
                alu_op    = ALU_LINK;
                writes_rd = 1'b1;
            end
            // Branches and unknown opcodes retire without a write
            default: ;
        endcase
    end

    imm_gen imm_gen_i (
        .instr     (instr),
        .immediate (immediate)
    );

    bu bu_i (
        .valid     (if_id.valid && en),
        .instr     (instr),
        .pc        (if_id.pc),
        .operand_a (rs1_val),
        .operand_b (rs2_val),
        .immediate (immediate),
        .if_ctrl   (if_ctrl)
    );

    register_file register_file_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .rs1        (instr.r.rs1),
        .rs2        (instr.r.rs2),
        .wb         (wb),
        .read_data1 (rf_data1),
        .read_data2 (rf_data2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (en) begin
            id_ex <= '{
                valid:     if_id.valid,
                pc:        if_id.pc,
                alu_op:    alu_op,
                operand_a: rs1_val,
                operand_b: uses_imm ? immediate : rs2_val,
                rd:        instr.r.rd,
                writes_rd: writes_rd && (instr.r.rd != 5'd0)
            };
        end
    end

endmodule

`default_nettype wire

/* verilog/exe.sv */
////////////////////
// Execute and writeback stage
// ALU result feeds decode forwarding and the registered commit entry
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module exe (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               en,
    input  riscv_pkg::id_ex_t  id_ex,
    output riscv_pkg::commit_t ex_fwd,
    output riscv_pkg::commit_t commit
);

    import riscv_pkg::*;

    logic [`RISCV_XLEN-1:0] a;
    logic [`RISCV_XLEN-1:0] b;
    logic [4:0]             shamt;
    logic [`RISCV_XLEN-1:0] result;
    commit_t                wb_q;

    assign a     = id_ex.operand_a;
    assign b     = id_ex.operand_b;
    assign shamt = b[4:0];

    always_comb begin
        case (id_ex.alu_op)
            ALU_ADD:    result = a + b;
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU:   result = {31'b0, a < b};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $unsigned($signed(a) >>> shamt);
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            ALU_LINK:   result = id_ex.pc + `RISCV_XLEN'd4;
            default:    result = '0;
        endcase
    end

    // Only real register writes are visible to decode
    assign ex_fwd = '{
        valid: id_ex.valid && id_ex.writes_rd,
        pc:    id_ex.pc,
        rd:    id_ex.rd,
        data:  result
    };

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else if (en) begin
            wb_q <= ex_fwd;
        end
    end

    // Held entry must not retire twice during a stall
    assign commit = '{valid: wb_q.valid && en, pc: wb_q.pc, rd: wb_q.rd, data: wb_q.data};

endmodule

`default_nettype wire

/* verilog/riscv_core.sv */
////////////////////
// RV32I core top, fetch, decode and execute/writeback in a row
// Instruction memory sits outside and answers in the same cycle
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module riscv_core (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   en,
    input  riscv_pkg::t_instr      instr,
    output logic [`RISCV_XLEN-1:0] instr_addr,
    output riscv_pkg::commit_t     commit
);

    import riscv_pkg::*;

    if_id_t   if_id;
    id_ex_t   id_ex;
    if_ctrl_t if_ctrl;
    commit_t  ex_fwd;

    fetch fetch_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .if_ctrl    (if_ctrl),
        .instr      (instr),
        .instr_addr (instr_addr),
        .if_id      (if_id)
    );

    // Commit doubles as the register-file write port
    dec dec_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .en      (en),
        .if_id   (if_id),
        .ex_fwd  (ex_fwd),
        .wb      (commit),
        .id_ex   (id_ex),
        .if_ctrl (if_ctrl)
    );

    exe exe_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .en     (en),
        .id_ex  (id_ex),
        .ex_fwd (ex_fwd),
        .commit (commit)
    );

endmodule

`default_nettype wire

/* testbench/tb_clock.sv */
////////////////////
// Free-running testbench clock, 10 ns period
////////////////////
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 10
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* testbench/tb_ref_model.svh */
////////////////////
// Random program builder and instruction-set reference for the core testbench
// Included inside the testbench module, works on its memory and commit queue
////////////////////
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

localparam logic [6:0] OP_REG = 7'b0110011;
localparam logic [6:0] OP_IMM = 7'b0010011;
localparam logic [6:0] OP_LUI = 7'b0110111;
localparam logic [6:0] OP_BR  = 7'b1100011;
localparam logic [6:0] OP_JAL = 7'b1101111;

// jal x0, 0 closes every program
localparam logic [31:0] JAL_SELF = {25'b0, OP_JAL};

localparam int PROG_ALU    = 0;
localparam int PROG_LUI_X0 = 1;
localparam int PROG_BRANCH = 2;
localparam int PROG_ODD    = 3;

// 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        fb;
    value = '0;
    for (int i = 0; i < n; i++) begin
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        value      = {value[30:0], fb};
    end
    return value;
endfunction

// Unused words decode as opcode zero
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    logic [31:0] mixed;
    mixed = (addr ^ 32'h5A5A_0F0F) * 32'h9E37_79B1;
    return {mixed[31:7], 7'b0000000};
endfunction

// Registers come from x0..x7 so that dependencies are dense
function automatic logic [4:0] pick_reg(input bit nonzero);
    logic [4:0] r;
    r = 5'(rand_bits(3));
    if (nonzero && r == 5'd0) begin
        r = 5'd1;
    end
    return r;
endfunction

function automatic logic [31:0] alu_word(input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input bit small_imm);
    logic [2:0]  f3;
    logic [2:0]  tiny;
    logic [11:0] imm;
    bit          alt;
    f3  = 3'(rand_bits(3));
    alt = rand_bits(1) == 32'd1;
    if (rand_bits(1) == 32'd1) begin
        alt = alt && (f3 == 3'b000 || f3 == 3'b101);
        return {alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd, OP_REG};
    end
    // Shift immediates carry funct7 in the upper bits
    if (f3 == 3'b001 || f3 == 3'b101) begin
        alt = alt && f3 == 3'b101;
        imm = {alt ? 7'b0100000 : 7'b0000000, 5'(rand_bits(5))};
    end else if (small_imm) begin
        tiny = 3'(rand_bits(3));
        imm  = {{9{tiny[2]}}, tiny};
    end else begin
        imm = 12'(rand_bits(12));
    end
    return {imm, rs1, f3, rd, OP_IMM};
endfunction

function automatic logic [31:0] branch_word(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input int off);
    logic [12:0] imm;
    logic [2:0]  f3;
    imm = 13'(off);
    f3  = 3'(rand_bits(3));
    // 010 and 011 are no branches, fold them onto 110 and 111
    if (f3[2:1] == 2'b01) begin
        f3[2] = 1'b1;
    end
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BR};
endfunction

function automatic logic [31:0] jal_word(input logic [4:0] rd, input int off);
    logic [20:0] imm;
    imm = 21'(off);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

// Load, store, auipc and jalr stand in for unsupported opcodes
function automatic logic [31:0] odd_word();
    logic [6:0] opc;
    case (2'(rand_bits(2)))
        2'd0:    opc = 7'b0000011;
        2'd1:    opc = 7'b0100011;
        2'd2:    opc = 7'b0010111;
        default: opc = 7'b1100111;
    endcase
    return {25'(rand_bits(25)), opc};
endfunction

// Branch and jal targets only point forward, at most up to the final loop
function automatic void build_program(input int kind, input int body);
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [2:0] sel;
    int         k;
    for (int i = 0; i < MEM_WORDS; i++) begin
        imem[i] = fill_word(32'(i) << 2);
    end
    for (int i = 0; i < body; i++) begin
        sel = 3'(rand_bits(3));
        k   = 1 + int'(rand_bits(2));
        if (i + k > body) begin
            k = body - i;
        end
        rd  = pick_reg(kind != PROG_LUI_X0);
        rs1 = pick_reg(1'b0);
        rs2 = pick_reg(1'b0);
        if (kind == PROG_LUI_X0 && sel < 3'd2) begin
            imem[i] = {20'(rand_bits(20)), rd, OP_LUI};
        end else if (kind >= PROG_BRANCH && sel == 3'd0) begin
            imem[i] = branch_word(rs1, rs2, k * 4);
        end else if (kind >= PROG_BRANCH && sel == 3'd1) begin
            imem[i] = jal_word(rd, k * 4);
        end else if (kind == PROG_ODD && sel == 3'd7) begin
            imem[i] = odd_word();
        end else begin
            imem[i] = alu_word(rd, rs1, rs2, kind >= PROG_BRANCH);
        end
    end
    imem[body] = JAL_SELF;
    prog_len   = body + 1;
endfunction

function automatic logic [31:0] alu_result(input logic [2:0] f3, input bit alt,
                                          input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'b011:  return (a < b) ? 32'd1 : 32'd0;
        3'b100:  return a ^ b;
        3'b101:  return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic bit branch_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        3'b111:  return a >= b;
        default: return 1'b0;
    endcase
endfunction

// Runs the program on an architectural model and queues every register write
function automatic int expected_commits();
    logic [31:0] x [32];
    logic [31:0] pc;
    logic [31:0] pc_next;
    logic [31:0] w;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [31:0] result;
    logic [4:0]  rd;
    logic [2:0]  f3;
    bit          writes;
    bit          alt;
    int          steps;
    commit_t     c;
    for (int r = 0; r < 32; r++) begin
        x[r] = '0;
    end
    exp_q.delete();
    pc    = `RISCV_RESET_PC;
    steps = 0;
    while (imem[pc[7:2]] != JAL_SELF && steps < 4 * MEM_WORDS) begin
        w       = imem[pc[7:2]];
        rd      = w[11:7];
        f3      = w[14:12];
        imm_i   = {{20{w[31]}}, w[31:20]};
        imm_b   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_j   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        alt     = w[30] && (w[6:0] == OP_REG || f3 == 3'b101);
        writes  = 1'b1;
        result  = '0;
        pc_next = pc + 32'd4;
        case (w[6:0])
            OP_REG: result = alu_result(f3, alt, x[w[19:15]], x[w[24:20]]);
            OP_IMM: result = alu_result(f3, alt, x[w[19:15]], imm_i);
            OP_LUI: result = {w[31:12], 12'b0};
            OP_JAL: begin
                result  = pc + 32'd4;
                pc_next = pc + imm_j;
            end
            OP_BR: begin
                writes = 1'b0;
                if (branch_taken(f3, x[w[19:15]], x[w[24:20]])) begin
                    pc_next = pc + imm_b;
                end
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != 5'd0) begin
            x[rd] = result;
            c     = '{valid: 1'b1, pc: pc, rd: rd, data: result};
            exp_q.push_back(c);
        end
        pc    = pc_next;
        steps = steps + 1;
    end
    return exp_q.size();
endfunction

`endif

/* testbench/riscv_core_tb.sv */
////////////////////
// Testbench for the RV32I core, random programs checked against reference commits
// Instruction memory is an array read combinationally at instr_addr
////////////////////
`default_nettype none
`include "riscv_settings.svh"

module riscv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import riscv_pkg::*;

    localparam int MEM_WORDS    = 64;
    localparam int DRAIN_CYCLES = 8;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    t_instr                 instr;
    logic [`RISCV_XLEN-1:0] instr_addr;
    commit_t                commit;

    logic [31:0] imem [MEM_WORDS];
    int          prog_len;
    commit_t     exp_q [$];
    commit_t     expected;
    logic [15:0] lfsr_state;

    string test_name;
    int    tests_run;
    int    checks;
    int    errors;
    int    n_expected;
    int    commit_count;
    int    cycle_count;
    int    low_cycles;
    int    cycle_limit;
    int    stall_left;
    logic  running;
    logic  checking;
    logic  stall_on;

    `include "tb_ref_model.svh"

    tb_clock clock_i (
        .clk (clk)
    );

    riscv_core riscv_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .instr      (instr),
        .instr_addr (instr_addr),
        .commit     (commit)
    );

    // Prefetch past the end of memory sees the fill pattern
    assign instr = (instr_addr[31:8] == '0) ? imem[instr_addr[7:2]] : fill_word(instr_addr);

    task automatic check_commit(input string what, input commit_t exp, input commit_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s (%s): expected pc %h x%0d=%h, actual pc %h x%0d=%h",
                     test_name, what, exp.pc, exp.rd, exp.data, act.pc, act.rd, act.data);
        end
    endtask

    task automatic check_addr(input string what, input logic [`RISCV_XLEN-1:0] exp,
                              input logic [`RISCV_XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s (%s): expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_flag(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s (%s): expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    // Random stretches of en low, 1 to 8 cycles each
    always @(negedge clk) begin
        if (!stall_on) begin
            stall_left = 0;
            en <= 1'b1;
        end else if (stall_left > 0) begin
            stall_left = stall_left - 1;
            en <= 1'b0;
        end else if (rand_bits(2) == 32'd0) begin
            stall_left = int'(rand_bits(3));
            en <= 1'b0;
        end else begin
            en <= 1'b1;
        end
    end

    // Compare retired writes in order with the reference queue
    always @(posedge clk) begin
        if (rst_n && checking && commit.valid) begin
            commit_count++;
            if (!en) begin
                errors++;
                $display("%s: commit at pc %h while en is low", test_name, commit.pc);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("%s: commit at pc %h to x%0d after the last expected one",
                         test_name, commit.pc, commit.rd);
            end else begin
                expected = exp_q.pop_front();
                check_commit("commit", expected, commit);
            end
        end
    end

    // En-low cycles extend the limit
    always @(posedge clk) begin
        if (running) begin
            cycle_count++;
            if (!en) begin
                low_cycles++;
            end
            if (cycle_count > cycle_limit + low_cycles) begin
                $display("timeout in %s: %0d of %0d commits seen after %0d cycles",
                         test_name, commit_count, n_expected, cycle_count);
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

    task automatic run_test(input string name, input int kind, input int body,
                            input bit stall, input bit check_reset);
        int errors_before;
        errors_before = errors;
        test_name     = name;
        tests_run++;
        @(negedge clk);
        rst_n    = 1'b0;
        checking = 1'b0;
        build_program(kind, body);
        n_expected   = expected_commits();
        commit_count = 0;
        repeat (4) @(negedge clk);
        if (check_reset) begin
            check_addr("pc in reset", `RISCV_RESET_PC, instr_addr);
            check_flag("commit valid in reset", 1'b0, commit.valid);
        end
        rst_n       = 1'b1;
        checking    = 1'b1;
        cycle_count = 0;
        low_cycles  = 0;
        cycle_limit = 4 * prog_len + 20;
        running     = 1'b1;
        if (check_reset) begin
            repeat (2) begin
                @(negedge clk);
                check_flag("commit valid before first retire", 1'b0, commit.valid);
            end
        end
        @(posedge clk);
        stall_on = stall;
        while (commit_count < n_expected) begin
            @(negedge clk);
        end
        @(posedge clk);
        stall_on = 1'b0;
        // Extra commits during the drain are flagged by the compare process
        repeat (DRAIN_CYCLES) @(negedge clk);
        running = 1'b0;
        $display("test %-12s %3d commits, %0d errors", name, commit_count,
                 errors - errors_before);
    endtask

    initial begin
        rst_n      = 1'b0;
        en         = 1'b0;
        running    = 1'b0;
        checking   = 1'b0;
        stall_on   = 1'b0;
        stall_left = 0;
        tests_run  = 0;
        checks     = 0;
        errors     = 0;
        lfsr_state = 16'd10016;
        for (int i = 0; i < MEM_WORDS; i++) begin
            imem[i] = fill_word(32'(i) << 2);
        end

        run_test("reset", PROG_ALU, 12, 1'b0, 1'b1);
        run_test("alu_forward", PROG_ALU, 50, 1'b0, 1'b0);
        run_test("lui_x0", PROG_LUI_X0, 40, 1'b0, 1'b0);
        run_test("branch_jal", PROG_BRANCH, 60, 1'b0, 1'b0);
        run_test("en_stall", PROG_BRANCH, 60, 1'b1, 1'b0);
        run_test("unsupported", PROG_ODD, 60, 1'b0, 1'b0);

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* riscv_core.f */
+incdir+verilog
+incdir+testbench
verilog/riscv_pkg.sv
verilog/imm_gen.sv
verilog/bu.sv
verilog/register_file.sv
verilog/fetch.sv
verilog/dec.sv
verilog/exe.sv
verilog/riscv_core.sv
testbench/tb_clock.sv
testbench/riscv_core_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles the core and its testbench with Verilator, runs the simulation,
# then looks for the fail message in the log.
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module riscv_core_tb -f riscv_core.f -o riscv_core_sim \
    && ./obj_dir/riscv_core_sim 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -qF '*** FAILED ***' sim.log \
    && { echo "simulation reported a failure"; exit 1; } \
    || { echo "simulation finished clean"; exit 0; }
